//--- Makefile
TOP := tb_rv_core
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
hdl/rv_core_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/rv_core_top.sv
tests/tb_rv_core.sv

//--- hdl/alu.sv
// integer alu with one shared add/subtract path, compares and shifts
`timescale 1ns/1ps
`default_nettype none

module alu import rv_core_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  alu_op_t          op,
    output logic [WIDTH-1:0] result
);

    localparam int SHIFT_W = $clog2(WIDTH);

    logic             sub_en;
    logic [WIDTH-1:0] b_eff;
    logic [WIDTH-1:0] sum;
    logic             overflow;
    logic             slt_bit;
    logic             sltu_bit;

    // compares reuse the subtractor
    assign sub_en   = (op == ALU_SUB) || (op == ALU_SLT) || (op == ALU_SLTU);
    assign b_eff    = b ^ {WIDTH{sub_en}};
    assign sum      = a + b_eff + {{(WIDTH-1){1'b0}}, sub_en};
    assign overflow = (a[WIDTH-1] == b_eff[WIDTH-1]) && (sum[WIDTH-1] != a[WIDTH-1]);
    assign slt_bit  = sum[WIDTH-1] ^ overflow;

    always_comb begin
        case ({a[WIDTH-1], b[WIDTH-1]})
            2'b01:   sltu_bit = 1'b1; // b larger unsigned
            2'b10:   sltu_bit = 1'b0;
            default: sltu_bit = sum[WIDTH-1]; // same msb, no wrap possible
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD, ALU_SUB: result = sum;
            ALU_AND:          result = a & b;
            ALU_OR:           result = a | b;
            ALU_XOR:          result = a ^ b;
            ALU_SLT:          result = {{(WIDTH-1){1'b0}}, slt_bit};
            ALU_SLTU:         result = {{(WIDTH-1){1'b0}}, sltu_bit};
            ALU_SLL:          result = a << b[SHIFT_W-1:0];
            ALU_SRL:          result = a >> b[SHIFT_W-1:0];
            ALU_SRA:          result = $signed(a) >>> b[SHIFT_W-1:0];
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
// instruction decoder, extracts fields, classifies format and builds the immediate
`timescale 1ns/1ps
`default_nettype none

module decode_unit import rv_core_pkg::*; (
    input  logic [XLEN-1:0] inst,
    output decoded_t        dec
);

    always_comb begin
        dec.opcode = inst[6:0];
        dec.funct3 = inst[14:12];
        dec.funct7 = inst[31:25];
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        case (inst[6:0])
            OP_REG:            dec.format = TYPE_R;
            OP_IMM, OP_JALR:   dec.format = TYPE_I;
            OP_BRANCH:         dec.format = TYPE_B;
            OP_LUI, OP_AUIPC:  dec.format = TYPE_U;
            OP_JAL:            dec.format = TYPE_J;
            default:           dec.format = TYPE_NONE; // unsupported opcode
        endcase

        case (dec.format)
            TYPE_I: begin
                dec.imm = {{20{inst[31]}}, inst[31:20]};
            end
            TYPE_B: begin
                dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                           inst[11:8], 1'b0};
            end
            TYPE_U: begin
                dec.imm = {inst[31:12], 12'b0};
            end
            TYPE_J: begin
                dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                           inst[30:21], 1'b0};
            end
            default: begin
                dec.imm = '0; // r-type and unknown
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
// execute stage with operand select, alu control, branch compare, jump target and write-back
`timescale 1ns/1ps
`default_nettype none

module execute_unit import rv_core_pkg::*; (
    input  decoded_t              dec,
    input  logic [XLEN-1:0]       src1,
    input  logic [XLEN-1:0]       src2,
    input  logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       snpc,
    output redirect_t             redirect,
    output logic                  rd_we,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output logic [XLEN-1:0]       rd_data
);

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    alu_op_t         alu_op;
    logic            branch_cond;
    logic            is_jalr;

    alu #(
        .WIDTH(XLEN)
    ) alu_inst (
        .a     (alu_a),
        .b     (alu_b),
        .op    (alu_op),
        .result(alu_result)
    );

    assign is_jalr = (dec.opcode == OP_JALR);

    always_comb begin
        case (dec.opcode)
            OP_IMM, OP_JALR: begin
                alu_a = src1;
                alu_b = dec.imm;
            end
            OP_AUIPC, OP_JAL, OP_BRANCH: begin
                alu_a = pc; // pc-relative target or sum
                alu_b = dec.imm;
            end
            OP_LUI: begin
                alu_a = '0;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = src1;
                alu_b = src2;
            end
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD; // address and upper-imm sums
        if (dec.opcode == OP_REG || dec.opcode == OP_IMM) begin
            case (dec.funct3)
                F3_ADD:  alu_op = (dec.opcode == OP_REG && dec.funct7[F7_ALT_BIT]) ?
                                  ALU_SUB : ALU_ADD;
                F3_SLL:  alu_op = ALU_SLL;
                F3_SLT:  alu_op = ALU_SLT;
                F3_SLTU: alu_op = ALU_SLTU;
                F3_XOR:  alu_op = ALU_XOR;
                F3_SR:   alu_op = dec.funct7[F7_ALT_BIT] ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (dec.funct3)
            F3_BEQ:  branch_cond = (src1 == src2);
            F3_BNE:  branch_cond = (src1 != src2);
            F3_BLT:  branch_cond = ($signed(src1) < $signed(src2));
            F3_BGE:  branch_cond = ($signed(src1) >= $signed(src2));
            F3_BLTU: branch_cond = (src1 < src2);
            F3_BGEU: branch_cond = (src1 >= src2);
            default: branch_cond = 1'b0; // reserved encodings fall through
        endcase
    end

    always_comb begin
        redirect.taken  = (dec.format == TYPE_J) || is_jalr ||
                          (dec.format == TYPE_B && branch_cond);
        redirect.target = is_jalr ? {alu_result[XLEN-1:1], 1'b0} : alu_result;
    end

    // links write snpc, everything else the alu result
    assign rd_data = (dec.format == TYPE_J || is_jalr) ? snpc : alu_result;
    assign rd_addr = dec.rd;
    assign rd_we   = (|dec.rd) && (dec.format == TYPE_R || dec.format == TYPE_I ||
                                   dec.format == TYPE_U || dec.format == TYPE_J);

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
// program counter with sequential next address and jump/branch redirect
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  redirect_t       redirect,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] snpc
);

    logic [XLEN-1:0] next_pc;

    assign snpc    = pc + XLEN'(4);
    assign next_pc = redirect.taken ? redirect.target : snpc; // jump or taken branch

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
// 32-entry integer register file, two read ports, one write port, x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 masked on read, whatever sits in entry zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
// rv32i core package with widths, opcodes, funct codes, enums and shared structs
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes recognised by the core
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // alu funct3
    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam int F7_ALT_BIT = 5; // funct7 bit picking sub / sra

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_NONE
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_t;

    typedef struct packed {
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        inst_t                 format;
    } decoded_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retire_t;

endpackage

`default_nettype wire

//--- hdl/rv_core_top.sv
// single-cycle rv32i core top, ties fetch, decode, execute and register file together
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] inst,
    output logic [XLEN-1:0] pc,
    output retire_t         retire
);

    logic [XLEN-1:0]       snpc;
    decoded_t              dec;
    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;
    redirect_t             redirect;
    logic                  rd_we;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_data;
    logic                  wb_we;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_inst (
        .clk     (clk),
        .reset   (reset),
        .redirect(redirect),
        .pc      (pc),
        .snpc    (snpc)
    );

    decode_unit decode_unit_inst (
        .inst(inst),
        .dec (dec)
    );

    execute_unit execute_unit_inst (
        .dec     (dec),
        .src1    (src1),
        .src2    (src2),
        .pc      (pc),
        .snpc    (snpc),
        .redirect(redirect),
        .rd_we   (rd_we),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    assign wb_we = rd_we && !reset; // nothing retires or writes during reset

    reg_file reg_file_inst (
        .clk   (clk),
        .we    (wb_we),
        .waddr (rd_addr),
        .wdata (rd_data),
        .raddr1(dec.rs1),
        .raddr2(dec.rs2),
        .rdata1(src1),
        .rdata2(src2)
    );

    always_comb begin
        retire.valid = wb_we;
        retire.pc    = pc;
        retire.rd    = rd_addr;
        retire.data  = rd_data; // value the register takes at the next edge
    end

endmodule

`default_nettype wire

//--- tests/tb_rv_core.sv
// directed testbench for the single-cycle rv32i core with an instruction memory model
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

    localparam logic [31:0] RESET_PC   = 32'h8000_0000;
    localparam logic [31:0] NOP        = 32'h0000_0013; // addi x0, x0, 0
    localparam int          MAX_CYCLES = 2000; // tests need about 400 cycles
    localparam logic [31:0] SEED       = 32'hcf18_57e0;

    logic        clk;
    logic        reset;
    logic [31:0] inst = NOP;
    logic [31:0] pc;
    retire_t     retire;

    logic [31:0] imem [logic [31:0]]; // sparse program memory, indexed by byte address
    retire_t     exp_q [$];           // expected retire per placed instruction
    logic [31:0] prog_base;
    logic [31:0] next_base = 32'h8000_1000;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    rv_core_top rv_core_top_inst (
        .clk   (clk),
        .reset (reset),
        .inst  (inst),
        .pc    (pc),
        .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        if ($isunknown(addr) || !imem.exists(addr)) begin
            return NOP; // unmapped space runs nops
        end
        return imem[addr];
    endfunction

    always @(negedge clk) begin
        inst <= fetch_word(pc);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped at the %0d cycle limit before the tests finished", MAX_CYCLES);
            $display("checks %0d errors %0d", checks, errors + 1);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(logic [4:0] rd, logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    // rv32i integer semantics, alt is funct7 bit 5
    function automatic logic [31:0] alu_result_of(logic [2:0] f3, logic alt,
                                                  logic [31:0] a, logic [31:0] b);
        logic signed [31:0] sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
            F3_SLTU: return {31'd0, a < b};
            F3_XOR:  return a ^ b;
            F3_SR:   return alt ? sra : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] next_addr();
        return prog_base + 32'(4 * exp_q.size());
    endfunction

    task automatic step_cycle();
        @(negedge clk);
        #1; // outputs settled after the new inst
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic new_program();
        prog_base = next_base;
        next_base += 32'h400;
        exp_q.delete();
    endtask

    // rd of zero means no retire expected
    task automatic place_inst(input logic [31:0] word, input logic [4:0] rd,
                              input logic [31:0] data);
        retire_t entry;
        entry.pc    = next_addr();
        entry.valid = (rd != 5'd0);
        entry.rd    = rd;
        entry.data  = data;
        imem[entry.pc] = word;
        exp_q.push_back(entry);
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800; // addi sign-extends its low 12 bits
        place_inst(u_type(hi[31:12], rd, OP_LUI), rd, {hi[31:12], 12'h000});
        place_inst(i_type(value[11:0], rd, F3_ADD, rd, OP_IMM), rd, value);
    endtask

    task automatic run_program(input string name);
        logic [31:0] entry_pc;
        while (imem.exists(pc)) begin
            step_cycle(); // leave the previous program
        end
        entry_pc = pc + 32'd4;
        imem[entry_pc] = j_type(5'd0, prog_base - entry_pc);
        step_cycle();
        compare_word({name, " entry valid"}, 32'd0, 32'(retire.valid));
        foreach (exp_q[i]) begin
            step_cycle();
            compare_word({name, " pc"}, exp_q[i].pc, pc);
            compare_word({name, " valid"}, 32'(exp_q[i].valid), 32'(retire.valid));
            if (exp_q[i].valid) begin
                compare_word({name, " retire pc"}, exp_q[i].pc, retire.pc);
                compare_word({name, " rd"}, 32'(exp_q[i].rd), 32'(retire.rd));
                compare_word({name, " data"}, exp_q[i].data, retire.data);
            end
        end
    endtask

    task automatic reset_sequence();
        imem[RESET_PC] = i_type(12'h5a5, 5'd0, F3_ADD, 5'd1, OP_IMM);
        @(posedge clk); // first reset edge
        repeat (3) begin
            step_cycle();
            compare_word("reset valid", 32'd0, 32'(retire.valid));
        end
        @(negedge clk);
        reset = 1'b0;
        #1;
        compare_word("reset pc", RESET_PC, pc);
        compare_word("reset first valid", 32'd1, 32'(retire.valid));
        compare_word("reset first data", 32'h0000_05a5, retire.data);
        for (int i = 1; i <= 4; i++) begin
            step_cycle();
            compare_word("reset nop pc", RESET_PC + 32'(4 * i), pc);
            compare_word("reset nop valid", 32'd0, 32'(retire.valid));
        end
    endtask

    task automatic imm_alu_test();
        logic [2:0]  f3s  [9] = '{F3_ADD, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND,
                                  F3_SLL, F3_SR, F3_SR};
        logic        alts [9] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        logic [31:0] a;
        logic [11:0] imm;
        new_program();
        for (int i = 0; i < 9; i++) begin
            a   = $urandom;
            imm = 12'($urandom);
            if (f3s[i] == F3_SLL || f3s[i] == F3_SR) begin
                imm = {1'b0, alts[i], 5'b0, imm[4:0]}; // shamt under funct7
            end
            set_reg(5'd10, a);
            place_inst(i_type(imm, 5'd10, f3s[i], 5'(i + 1), OP_IMM), 5'(i + 1),
                       alu_result_of(f3s[i], alts[i], a, {{20{imm[11]}}, imm}));
        end
        run_program("imm alu");
    endtask

    task automatic reg_alu_test();
        logic [2:0]  f3s  [10] = '{F3_ADD, F3_ADD, F3_SLL, F3_SLT, F3_SLTU, F3_XOR,
                                   F3_SR, F3_SR, F3_OR, F3_AND};
        logic        alts [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
                                   1'b0, 1'b0};
        logic [31:0] a_vals [4] = '{32'h0, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
        logic [31:0] b_vals [4] = '{32'h0, 32'h7fff_ffff, 32'h8000_0000, 32'h0000_0001};
        new_program();
        a_vals[0] = $urandom;
        b_vals[0] = $urandom;
        for (int s = 0; s < 4; s++) begin
            set_reg(5'd11, a_vals[s]);
            set_reg(5'd12, b_vals[s]);
            for (int i = 0; i < 10; i++) begin
                place_inst(r_type({1'b0, alts[i], 5'b0}, 5'd12, 5'd11, f3s[i], 5'(i + 1)),
                           5'(i + 1), alu_result_of(f3s[i], alts[i], a_vals[s], b_vals[s]));
            end
        end
        // a nonzero write to x0 must not stick
        place_inst(r_type(7'h00, 5'd12, 5'd11, F3_OR, 5'd0), 5'd0, 32'd0);
        place_inst(r_type(7'h00, 5'd12, 5'd0, F3_ADD, 5'd13), 5'd13, b_vals[3]);
        run_program("reg alu");
    endtask

    task automatic upper_imm_test();
        logic [19:0] imm;
        new_program();
        for (int i = 0; i < 3; i++) begin
            imm = 20'($urandom);
            place_inst(u_type(imm, 5'(i + 1), OP_LUI), 5'(i + 1), {imm, 12'h000});
            place_inst(u_type(imm, 5'(i + 4), OP_AUIPC), 5'(i + 4),
                       next_addr() + {imm, 12'h000});
        end
        run_program("upper imm");
    endtask

    task automatic jump_test();
        logic [31:0] jump_pc;
        logic [31:0] base;
        new_program();
        jump_pc = next_addr();
        place_inst(j_type(5'd5, 32'd24), 5'd5, jump_pc + 32'd4);
        run_program("jal");
        step_cycle();
        compare_word("jal target", jump_pc + 32'd24, pc);
        new_program();
        base = prog_base + 32'h31; // odd sum, bit 0 must drop
        set_reg(5'd6, base);
        jump_pc = next_addr();
        place_inst(i_type(12'h010, 5'd6, 3'b000, 5'd7, OP_JALR), 5'd7, jump_pc + 32'd4);
        run_program("jalr");
        step_cycle();
        compare_word("jalr target", (base + 32'h10) & ~32'd1, pc);
    endtask

    task automatic branch_test();
        logic [2:0]  f3s [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] lhs [3];
        logic [31:0] rhs [3];
        logic [31:0] br_pc;
        for (int c = 0; c < 6; c++) begin
            x   = $urandom | 32'h8000_0000; // negative, large unsigned
            y   = $urandom & 32'h7fff_ffff;
            lhs = '{x, x, y};
            rhs = '{x, y, x};
            for (int p = 0; p < 3; p++) begin
                new_program();
                set_reg(5'd11, lhs[p]);
                set_reg(5'd12, rhs[p]);
                br_pc = next_addr();
                place_inst(b_type(f3s[c], 5'd11, 5'd12, 13'd16), 5'd0, 32'd0);
                run_program("branch");
                step_cycle();
                compare_word("branch next pc",
                             br_pc + (branch_taken(f3s[c], lhs[p], rhs[p]) ? 32'd16 : 32'd4),
                             pc);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        void'($urandom(SEED));
        reset_sequence();
        imm_alu_test();
        reg_alu_test();
        upper_imm_test();
        jump_test();
        branch_test();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
